// ==== logic/mips_pkg.sv ====
`default_nettype none

package mips_pkg;

	typedef logic [31:0] word_t; // Data or address word
	typedef logic [4:0] reg_addr_t; // GPR index

	// Primary opcodes, instr[31:26]
	typedef enum logic [5:0] {
		OP_SPECIAL = 6'h00, // R-type, decoded by funct
		OP_J       = 6'h02,
		OP_JAL     = 6'h03,
		OP_BEQ     = 6'h04,
		OP_BNE     = 6'h05,
		OP_ADDIU   = 6'h09,
		OP_SLTI    = 6'h0A,
		OP_SLTIU   = 6'h0B,
		OP_ANDI    = 6'h0C,
		OP_ORI     = 6'h0D,
		OP_XORI    = 6'h0E,
		OP_LUI     = 6'h0F,
		OP_LW      = 6'h23,
		OP_SW      = 6'h2B
	} opcode_e;

	// Funct codes under SPECIAL, instr[5:0]
	typedef enum logic [5:0] {
		FN_SLL  = 6'h00,
		FN_SRL  = 6'h02,
		FN_SRA  = 6'h03,
		FN_JR   = 6'h08,
		FN_ADDU = 6'h21,
		FN_SUBU = 6'h23,
		FN_AND  = 6'h24,
		FN_OR   = 6'h25,
		FN_XOR  = 6'h26,
		FN_SLT  = 6'h2A,
		FN_SLTU = 6'h2B
	} funct_e;

	typedef enum logic [3:0] {
		ALU_ADD  = 4'd0,
		ALU_SUB  = 4'd1,
		ALU_AND  = 4'd2,
		ALU_OR   = 4'd3,
		ALU_XOR  = 4'd4,
		ALU_NONE = 4'd5, // Reserved slot, result is zero
		ALU_SLT  = 4'd6,
		ALU_SLTU = 4'd7,
		ALU_SLL  = 4'd8,
		ALU_SRL  = 4'd9,
		ALU_SRA  = 4'd10,
		ALU_LUI  = 4'd11
	} alu_op_e;

	typedef enum logic [1:0] {DST_RT = 2'd0, DST_RD = 2'd1, DST_R31 = 2'd2} dst_sel_e;
	typedef enum logic [1:0] {RES_ALU = 2'd0, RES_MEM = 2'd1, RES_LINK = 2'd2} result_sel_e;

	typedef struct packed {
		logic reg_write; // GPR write at retire
		dst_sel_e dst_sel; // Which field names the destination
		logic alu_src_imm; // ALU b from immediate
		logic imm_zero_ext; // Logical immediates
		logic shift_by_shamt; // Shift amount from instr[10:6]
		logic mem_read;
		logic mem_write;
		result_sel_e result_sel; // Writeback source
		logic branch_eq;
		logic branch_ne;
		logic jump; // J and JAL
		logic jump_reg; // JR
		alu_op_e alu_op;
		logic valid; // Recognised encoding
	} ctrl_t;

endpackage

`default_nettype wire

// ==== logic/instr_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module instr_decoder (
	input  mips_pkg::word_t instr,
	output mips_pkg::ctrl_t ctrl
);

	mips_pkg::opcode_e opcode;
	mips_pkg::funct_e funct;

	assign opcode = mips_pkg::opcode_e'(instr[31:26]);
	assign funct = mips_pkg::funct_e'(instr[5:0]);

	always_comb begin
		ctrl = '0; // Invalid and harmless unless matched below
		case (opcode)
			mips_pkg::OP_SPECIAL: begin
				ctrl.valid = 1'b1;
				ctrl.reg_write = 1'b1;
				ctrl.dst_sel = mips_pkg::DST_RD;
				case (funct)
					mips_pkg::FN_ADDU: ctrl.alu_op = mips_pkg::ALU_ADD;
					mips_pkg::FN_SUBU: ctrl.alu_op = mips_pkg::ALU_SUB;
					mips_pkg::FN_AND:  ctrl.alu_op = mips_pkg::ALU_AND;
					mips_pkg::FN_OR:   ctrl.alu_op = mips_pkg::ALU_OR;
					mips_pkg::FN_XOR:  ctrl.alu_op = mips_pkg::ALU_XOR;
					mips_pkg::FN_SLT:  ctrl.alu_op = mips_pkg::ALU_SLT;
					mips_pkg::FN_SLTU: ctrl.alu_op = mips_pkg::ALU_SLTU;
					mips_pkg::FN_SLL, mips_pkg::FN_SRL, mips_pkg::FN_SRA: begin
						ctrl.shift_by_shamt = 1'b1; // Constant shifts only
						ctrl.alu_op = (funct == mips_pkg::FN_SLL) ? mips_pkg::ALU_SLL :
							(funct == mips_pkg::FN_SRL) ? mips_pkg::ALU_SRL : mips_pkg::ALU_SRA;
					end
					mips_pkg::FN_JR: begin
						ctrl.reg_write = 1'b0; // Target is rs, nothing written
						ctrl.jump_reg = 1'b1;
					end
					default: begin
						ctrl.valid = 1'b0;
						ctrl.reg_write = 1'b0;
					end
				endcase
			end
			mips_pkg::OP_ADDIU, mips_pkg::OP_SLTI, mips_pkg::OP_SLTIU, mips_pkg::OP_ANDI,
			mips_pkg::OP_ORI, mips_pkg::OP_XORI, mips_pkg::OP_LUI: begin
				ctrl.valid = 1'b1;
				ctrl.reg_write = 1'b1; // Destination is rt
				ctrl.alu_src_imm = 1'b1;
				case (opcode)
					mips_pkg::OP_SLTI:  ctrl.alu_op = mips_pkg::ALU_SLT;
					mips_pkg::OP_SLTIU: ctrl.alu_op = mips_pkg::ALU_SLTU; // Sign extended, unsigned compare
					mips_pkg::OP_LUI:   ctrl.alu_op = mips_pkg::ALU_LUI;
					mips_pkg::OP_ANDI:  ctrl.alu_op = mips_pkg::ALU_AND;
					mips_pkg::OP_ORI:   ctrl.alu_op = mips_pkg::ALU_OR;
					mips_pkg::OP_XORI:  ctrl.alu_op = mips_pkg::ALU_XOR;
					default:            ctrl.alu_op = mips_pkg::ALU_ADD;
				endcase
				ctrl.imm_zero_ext = (opcode == mips_pkg::OP_ANDI) || (opcode == mips_pkg::OP_ORI) ||
					(opcode == mips_pkg::OP_XORI);
			end
			mips_pkg::OP_LW: begin
				ctrl.valid = 1'b1;
				ctrl.reg_write = 1'b1;
				ctrl.alu_src_imm = 1'b1; // Base plus offset
				ctrl.mem_read = 1'b1;
				ctrl.result_sel = mips_pkg::RES_MEM;
			end
			mips_pkg::OP_SW: begin
				ctrl.valid = 1'b1;
				ctrl.alu_src_imm = 1'b1;
				ctrl.mem_write = 1'b1;
			end
			mips_pkg::OP_BEQ, mips_pkg::OP_BNE: begin
				ctrl.valid = 1'b1;
				ctrl.alu_op = mips_pkg::ALU_SUB; // Zero flag compares rs and rt
				ctrl.branch_eq = (opcode == mips_pkg::OP_BEQ);
				ctrl.branch_ne = (opcode == mips_pkg::OP_BNE);
			end
			mips_pkg::OP_J: begin
				ctrl.valid = 1'b1;
				ctrl.jump = 1'b1;
			end
			mips_pkg::OP_JAL: begin
				ctrl.valid = 1'b1;
				ctrl.jump = 1'b1;
				ctrl.reg_write = 1'b1;
				ctrl.dst_sel = mips_pkg::DST_R31; // Link to ra
				ctrl.result_sel = mips_pkg::RES_LINK;
			end
			default: ctrl = '0;
		endcase
	end

endmodule

`default_nettype wire

// ==== logic/alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu (
	input  mips_pkg::alu_op_e op,
	input  mips_pkg::word_t a,
	input  mips_pkg::word_t b,
	input  logic [4:0] shamt,
	output mips_pkg::word_t result,
	output logic zero
);

	always_comb begin
		case (op)
			mips_pkg::ALU_ADD: begin
				result = a + b; // No overflow trap
			end
			mips_pkg::ALU_SUB: begin
				result = a - b;
			end
			mips_pkg::ALU_AND: begin
				result = a & b;
			end
			mips_pkg::ALU_OR: begin
				result = a | b;
			end
			mips_pkg::ALU_XOR: begin
				result = a ^ b;
			end
			mips_pkg::ALU_SLT: begin
				result = {31'b0, $signed(a) < $signed(b)};
			end
			mips_pkg::ALU_SLTU: begin
				result = {31'b0, a < b};
			end
			mips_pkg::ALU_SLL: begin
				result = b << shamt; // Shifts act on rt
			end
			mips_pkg::ALU_SRL: begin
				result = b >> shamt;
			end
			mips_pkg::ALU_SRA: begin
				result = $signed(b) >>> shamt; // Sign fill
			end
			mips_pkg::ALU_LUI: begin
				result = {b[15:0], 16'b0};
			end
			default: begin
				result = '0; // ALU_NONE and unused codes
			end
		endcase
	end

	assign zero = (result == '0); // Used for BEQ and BNE

endmodule

`default_nettype wire

// ==== logic/reg_file.sv ====
`timescale 1ns/1ps
`default_nettype none

module reg_file (
	input  logic clk,
	input  logic reset,
	input  logic we,
	input  mips_pkg::reg_addr_t ra1,
	input  mips_pkg::reg_addr_t ra2,
	input  mips_pkg::reg_addr_t wa,
	input  mips_pkg::word_t wd,
	output mips_pkg::word_t rd1,
	output mips_pkg::word_t rd2,
	output mips_pkg::word_t v0
);

	mips_pkg::word_t regs [0:31];

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0; // Whole file starts clean
			end
		end else if (we && (wa != '0)) begin
			regs[wa] <= wd; // Writes to zero are dropped
		end
	end

	// Two asynchronous read ports
	assign rd1 = (ra1 == '0) ? '0 : regs[ra1];
	assign rd2 = (ra2 == '0) ? '0 : regs[ra2];
	assign v0 = regs[2]; // Result register view

endmodule

`default_nettype wire

// ==== logic/mips_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module mips_core #(
	parameter mips_pkg::word_t RESET_VECTOR = 32'hBFC00000
) (
	input  logic clk,
	input  logic reset,
	input  logic clk_enable,
	output logic active,
	output mips_pkg::word_t register_v0,
	output mips_pkg::word_t instr_address,
	input  mips_pkg::word_t instr_readdata,
	output mips_pkg::word_t data_address,
	output logic data_write,
	output logic data_read,
	output mips_pkg::word_t data_writedata,
	input  mips_pkg::word_t data_readdata
);

	mips_pkg::word_t pc;
	mips_pkg::word_t next_pc;
	mips_pkg::word_t pc_plus4;
	mips_pkg::word_t imm_ext;
	mips_pkg::word_t branch_target;
	mips_pkg::word_t jump_target;
	mips_pkg::word_t rd1;
	mips_pkg::word_t rd2;
	mips_pkg::word_t alu_b;
	mips_pkg::word_t alu_result;
	mips_pkg::word_t wb_data;
	mips_pkg::reg_addr_t dst_addr;
	mips_pkg::ctrl_t ctrl;
	logic [4:0] shamt;
	logic alu_zero;
	logic branch_taken;
	logic retire; // This edge commits one instruction
	logic reg_we;

	instr_decoder u_decoder (.instr(instr_readdata), .ctrl(ctrl));

	reg_file u_regs (
		.clk(clk), .reset(reset), .we(reg_we),
		.ra1(instr_readdata[25:21]), .ra2(instr_readdata[20:16]), .wa(dst_addr),
		.wd(wb_data), .rd1(rd1), .rd2(rd2), .v0(register_v0)
	);

	alu u_alu (
		.op(ctrl.alu_op), .a(rd1), .b(alu_b), .shamt(shamt),
		.result(alu_result), .zero(alu_zero)
	);

	assign retire = clk_enable && active;
	assign instr_address = pc;

	// Immediate and targets
	assign imm_ext = ctrl.imm_zero_ext ? {16'b0, instr_readdata[15:0]} :
		{{16{instr_readdata[15]}}, instr_readdata[15:0]};
	assign pc_plus4 = pc + 32'd4; // Also the link value, no delay slot
	assign branch_target = pc_plus4 + {imm_ext[29:0], 2'b00};
	assign jump_target = {pc_plus4[31:28], instr_readdata[25:0], 2'b00};

	assign alu_b = ctrl.alu_src_imm ? imm_ext : rd2;
	assign shamt = ctrl.shift_by_shamt ? instr_readdata[10:6] : 5'd0;
	assign branch_taken = (ctrl.branch_eq && alu_zero) || (ctrl.branch_ne && !alu_zero);

	always_comb begin
		if (ctrl.jump_reg) next_pc = rd1;
		else if (ctrl.jump) next_pc = jump_target;
		else if (branch_taken) next_pc = branch_target;
		else next_pc = pc_plus4; // Includes invalid encodings
	end

	always_comb begin
		case (ctrl.dst_sel)
			mips_pkg::DST_RD:  dst_addr = instr_readdata[15:11];
			mips_pkg::DST_R31: dst_addr = 5'd31;
			default:           dst_addr = instr_readdata[20:16];
		endcase
		case (ctrl.result_sel)
			mips_pkg::RES_MEM:  wb_data = data_readdata;
			mips_pkg::RES_LINK: wb_data = pc_plus4;
			default:            wb_data = alu_result;
		endcase
	end

	// Strobes only on a retiring cycle
	assign reg_we = retire && ctrl.valid && ctrl.reg_write;
	assign data_read = retire && ctrl.valid && ctrl.mem_read;
	assign data_write = retire && ctrl.valid && ctrl.mem_write;
	assign data_address = alu_result; // Base plus offset
	assign data_writedata = rd2;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			pc <= RESET_VECTOR;
			active <= 1'b1;
		end else if (retire) begin
			pc <= next_pc;
			if (next_pc == '0) active <= 1'b0; // Jump to zero halts
		end
	end

	a_data_aligned: assert property (@(posedge clk) disable iff (reset)
		(data_read || data_write) |-> (data_address[1:0] == 2'b00));

	a_fetch_aligned: assert property (@(posedge clk) disable iff (reset)
		active |-> (instr_address[1:0] == 2'b00));

endmodule

`default_nettype wire

// ==== bench/mips_core_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module mips_core_tb;

	localparam mips_pkg::word_t RESET_VECTOR = 32'hBFC00000;
	localparam mips_pkg::word_t DATA_BASE = 32'h00000100;
	localparam int CLK_PERIOD = 40;
	localparam int N_PROGS = 20;
	localparam int N_INSTR = 60;

	logic clk, reset, clk_enable, active, data_write, data_read;
	mips_pkg::word_t register_v0, instr_address, instr_readdata;
	mips_pkg::word_t data_address, data_writedata, data_readdata, i_off, d_off;
	mips_pkg::word_t imem [0:255]; // Program at the reset vector
	mips_pkg::word_t dmem [0:63]; // Data window at DATA_BASE
	mips_pkg::word_t prog [0:N_INSTR-1];
	mips_pkg::word_t m_regs [0:31]; // ISS registers
	mips_pkg::word_t m_mem [0:63]; // ISS data memory
	mips_pkg::word_t m_pc;
	logic m_active;

	mips_core #(.RESET_VECTOR(RESET_VECTOR)) dut (
		.clk(clk), .reset(reset), .clk_enable(clk_enable), .active(active),
		.register_v0(register_v0), .instr_address(instr_address),
		.instr_readdata(instr_readdata), .data_address(data_address),
		.data_write(data_write), .data_read(data_read),
		.data_writedata(data_writedata), .data_readdata(data_readdata)
	);

	function automatic mips_pkg::word_t fill_word(int k);
		mips_pkg::word_t addr;
		addr = DATA_BASE + mips_pkg::word_t'(4 * k);
		return {addr[15:0] ^ 16'hC3A5, ~addr[15:0]} ^ (addr << 9); // Whole address mixed in
	endfunction

	// Both memories answer in the same cycle, zero outside their windows
	assign i_off = instr_address - RESET_VECTOR;
	assign d_off = data_address - DATA_BASE;
	assign instr_readdata = (i_off < 32'd1024) ? imem[i_off[9:2]] : '0;
	assign data_readdata = (d_off < 32'd256) ? dmem[d_off[7:2]] : '0;

	always @(posedge clk or posedge reset) begin
		if (reset) begin
			for (int k = 0; k < 64; k++) dmem[k] <= fill_word(k); // Same contents as the ISS
		end else if (data_write && d_off < 32'd256) begin
			dmem[d_off[7:2]] <= data_writedata; // Store lands at the retiring edge
		end
	end

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	initial begin
		#(N_PROGS * (N_INSTR * 4 + 10) * CLK_PERIOD); // Budget per program incl. stalls
		$display("Timeout at %0t: the core never halted", $time);
		stop_run();
	end

	task automatic stop_run();
		$display("Simulation failed");
		$fatal(1, "Run stopped at the first error");
	endtask

	task automatic check_fetch(mips_pkg::word_t exp, mips_pkg::word_t act);
		if (act !== exp) begin
			$display("FAILED %0t: instr_address %h, expected %h", $time, act, exp);
			stop_run();
		end
	endtask

	task automatic check_v0(mips_pkg::word_t exp, mips_pkg::word_t act);
		if (act !== exp) begin
			$display("FAILED %0t: register_v0 %h, expected %h", $time, act, exp);
			stop_run();
		end
	endtask

	task automatic check_store(mips_pkg::word_t exp_addr, act_addr, exp_data, act_data);
		if (act_addr !== exp_addr || act_data !== exp_data) begin
			$display("FAILED %0t: store [%h] <= %h, expected [%h] <= %h", $time,
				act_addr, act_data, exp_addr, exp_data);
			stop_run();
		end
	endtask

	task automatic check_load(mips_pkg::word_t exp_addr, act_addr, exp_data, act_data);
		if (act_addr !== exp_addr || act_data !== exp_data) begin
			$display("FAILED %0t: load [%h] = %h, expected [%h] = %h", $time,
				act_addr, act_data, exp_addr, exp_data);
			stop_run();
		end
	endtask

	task automatic check_flag(string what, logic exp, logic act);
		if (act !== exp) begin
			$display("FAILED %0t: %s is %b, expected %b", $time, what, act, exp);
			stop_run();
		end
	endtask

	function automatic mips_pkg::word_t r_type(mips_pkg::funct_e fn,
		mips_pkg::reg_addr_t rs, rt, rd, logic [4:0] sh);
		return {6'h00, rs, rt, rd, sh, fn};
	endfunction

	function automatic mips_pkg::word_t i_type(mips_pkg::opcode_e op,
		mips_pkg::reg_addr_t rs, rt, logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic mips_pkg::reg_addr_t pick_reg();
		int r;
		r = int'($urandom % 9);
		return (r == 8) ? 5'd31 : mips_pkg::reg_addr_t'(r); // r0 to r7, or ra
	endfunction

	function automatic mips_pkg::word_t gen_instr(int i);
		mips_pkg::reg_addr_t rs, rt, rd;
		logic [15:0] imm;
		mips_pkg::word_t target;
		int span;
		rs = pick_reg();
		rt = pick_reg();
		rd = pick_reg();
		imm = 16'($urandom);
		span = N_INSTR - 1 - i; // Slots after i up to the final JR
		target = RESET_VECTOR + mips_pkg::word_t'(4 * (i + 1 + int'($urandom % span)));
		case ($urandom % 23)
			0: return r_type(mips_pkg::FN_ADDU, rs, rt, rd, 5'd0);
			1: return r_type(mips_pkg::FN_SUBU, rs, rt, rd, 5'd0);
			2: return r_type(mips_pkg::FN_AND, rs, rt, rd, 5'd0);
			3: return r_type(mips_pkg::FN_OR, rs, rt, rd, 5'd0);
			4: return r_type(mips_pkg::FN_XOR, rs, rt, rd, 5'd0);
			5: return r_type(mips_pkg::FN_SLT, rs, rt, rd, 5'd0);
			6: return r_type(mips_pkg::FN_SLTU, rs, rt, rd, 5'd0);
			7: return r_type(mips_pkg::FN_SLL, 5'd0, rt, rd, imm[4:0]);
			8: return r_type(mips_pkg::FN_SRL, 5'd0, rt, rd, imm[4:0]);
			9: return r_type(mips_pkg::FN_SRA, 5'd0, rt, rd, imm[4:0]);
			10: return i_type(mips_pkg::OP_ADDIU, rs, rt, imm);
			11: return i_type(mips_pkg::OP_SLTI, rs, rt, imm);
			12: return i_type(mips_pkg::OP_SLTIU, rs, rt, imm);
			13: return i_type(mips_pkg::OP_ANDI, rs, rt, imm);
			14: return i_type(mips_pkg::OP_ORI, rs, rt, imm);
			15: return i_type(mips_pkg::OP_XORI, rs, rt, imm);
			16: return i_type(mips_pkg::OP_LUI, 5'd0, rt, imm);
			17: return i_type(mips_pkg::OP_LW, 5'd0, rt, 16'(DATA_BASE + 4 * ($urandom % 64)));
			18: return i_type(mips_pkg::OP_SW, 5'd0, rt, 16'(DATA_BASE + 4 * ($urandom % 64)));
			19: return i_type(mips_pkg::OP_BEQ, rs, rt, 16'($urandom % span)); // Forward only
			20: return i_type(mips_pkg::OP_BNE, rs, rt, 16'($urandom % span));
			21: return {mips_pkg::OP_J, target[27:2]};
			default: return {mips_pkg::OP_JAL, target[27:2]};
		endcase
	endfunction

	// ISS, one call per retiring edge
	task automatic model_step(output logic st, output logic ld,
		output mips_pkg::word_t ea, output mips_pkg::word_t ed);
		mips_pkg::word_t ins, a, b, se, npc, wv;
		mips_pkg::reg_addr_t wa;
		logic wr;
		ins = prog[int'((m_pc - RESET_VECTOR) >> 2)];
		a = m_regs[ins[25:21]];
		b = m_regs[ins[20:16]];
		se = {{16{ins[15]}}, ins[15:0]};
		npc = m_pc + 32'd4;
		wa = ins[20:16]; // rt unless overridden
		wv = '0;
		wr = 1'b1;
		st = 1'b0;
		ld = 1'b0;
		ea = a + se;
		ed = b;
		case (ins[31:26])
			mips_pkg::OP_SPECIAL: begin
				wa = ins[15:11];
				case (ins[5:0])
					mips_pkg::FN_ADDU: wv = a + b;
					mips_pkg::FN_SUBU: wv = a - b;
					mips_pkg::FN_AND: wv = a & b;
					mips_pkg::FN_OR: wv = a | b;
					mips_pkg::FN_XOR: wv = a ^ b;
					mips_pkg::FN_SLT: wv = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
					mips_pkg::FN_SLTU: wv = (a < b) ? 32'd1 : 32'd0;
					mips_pkg::FN_SLL: wv = b << ins[10:6];
					mips_pkg::FN_SRL: wv = b >> ins[10:6];
					mips_pkg::FN_SRA: wv = mips_pkg::word_t'($signed(b) >>> ins[10:6]);
					default: begin // JR
						wr = 1'b0;
						npc = a;
					end
				endcase
			end
			mips_pkg::OP_ADDIU: wv = a + se;
			mips_pkg::OP_SLTI: wv = ($signed(a) < $signed(se)) ? 32'd1 : 32'd0;
			mips_pkg::OP_SLTIU: wv = (a < se) ? 32'd1 : 32'd0; // Sign-extended, unsigned compare
			mips_pkg::OP_ANDI: wv = a & {16'h0, ins[15:0]};
			mips_pkg::OP_ORI: wv = a | {16'h0, ins[15:0]};
			mips_pkg::OP_XORI: wv = a ^ {16'h0, ins[15:0]};
			mips_pkg::OP_LUI: wv = {ins[15:0], 16'h0};
			mips_pkg::OP_LW: begin
				ld = 1'b1;
				wv = m_mem[ea[7:2]]; // Window base is 256-byte aligned
				ed = wv;
			end
			mips_pkg::OP_SW: begin
				wr = 1'b0;
				st = 1'b1;
				m_mem[ea[7:2]] = b;
			end
			mips_pkg::OP_BEQ, mips_pkg::OP_BNE: begin
				wr = 1'b0;
				if ((a == b) == (ins[31:26] == mips_pkg::OP_BEQ)) npc = npc + (se << 2);
			end
			default: begin // J and JAL
				wr = (ins[31:26] == mips_pkg::OP_JAL);
				wa = 5'd31;
				wv = npc; // Link is PC+4
				npc = {npc[31:28], ins[25:0], 2'b00};
			end
		endcase
		if (wr && wa != 5'd0) m_regs[wa] = wv; // r0 stays zero
		m_pc = npc;
		if (npc == '0) m_active = 1'b0; // Halt on jump to zero
	endtask

	task automatic check_cycle();
		logic st, ld;
		mips_pkg::word_t ea, ed;
		check_flag("active", m_active, active);
		check_v0(m_regs[2], register_v0);
		if (m_active) check_fetch(m_pc, instr_address); // Frozen while clk_enable low
		st = 1'b0;
		ld = 1'b0;
		if (m_active && clk_enable) model_step(st, ld, ea, ed);
		check_flag("data_write", st, data_write);
		check_flag("data_read", ld, data_read);
		if (st) check_store(ea, data_address, ed, data_writedata);
		if (ld) check_load(ea, data_address, ed, data_readdata);
	endtask

	task automatic run_program();
		int tail;
		for (int i = 0; i < N_INSTR - 1; i++) prog[i] = gen_instr(i);
		prog[N_INSTR-1] = r_type(mips_pkg::FN_JR, 5'd0, 5'd0, 5'd0, 5'd0); // Jump to zero
		for (int k = 0; k < 256; k++) imem[k] = (k < N_INSTR) ? prog[k] : '0;
		for (int k = 0; k < 32; k++) m_regs[k] = '0;
		for (int k = 0; k < 64; k++) m_mem[k] = fill_word(k);
		m_pc = RESET_VECTOR;
		m_active = 1'b1;
		tail = 0;
		@(posedge clk);
		#2;
		reset = 1'b1;
		clk_enable = 1'b0;
		repeat (4) @(posedge clk);
		#2;
		reset = 1'b0;
		while (tail < 5) begin // A few cycles past halt
			clk_enable = ($urandom % 4) != 0; // Low about a quarter of the time
			@(negedge clk);
			check_cycle();
			if (!m_active) tail++;
			@(posedge clk);
			#2;
		end
	endtask

	initial begin
		void'($urandom(34));
		reset = 1'b1;
		clk_enable = 1'b0;
		for (int p = 0; p < N_PROGS; p++) run_program();
		$display("Simulation passed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== src.f ====
logic/mips_pkg.sv
logic/instr_decoder.sv
logic/alu.sv
logic/reg_file.sv
logic/mips_core.sv
bench/mips_core_tb.sv

// ==== Makefile ====
TOP := mips_core_tb
SIM := obj_dir/V$(TOP)

.PHONY: all run clean

all: $(SIM)

$(SIM): src.f $(wildcard logic/*.sv bench/*.sv)
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f src.f

run: $(SIM)
	@out="$$($(SIM))"; echo "$$out"; echo "$$out" | grep -qx "Simulation passed"

clean:
	rm -rf obj_dir
